/* conv_feeder.f */
+incdir+design
design/buffer_pkg.sv
design/window_pkg.sv
design/feeder_ifs.sv
design/pixel_writer.sv
design/line_buffer_ram.sv
design/window_addr_gen.sv
design/lane_skew.sv
design/conv_feeder.sv
tb/tb_clock.sv
tb/tb_conv_feeder.sv

/* design/buffer_pkg.sv */
`include "feeder_macros.svh"

package buffer_pkg;

	// one value for one lane of the array
	typedef logic [`FEEDER_LANE_WIDTH-1:0] lane_t;

	// one pixel with lane 0 in the low bits
	typedef logic [`FEEDER_LANES*`FEEDER_LANE_WIDTH-1:0] word_t;

	// ring row times max columns plus column
	typedef logic [$clog2(`FEEDER_RING_ROWS*`FEEDER_MAX_COLS)-1:0] buf_addr_t;

endpackage

/* design/conv_feeder.sv */
`timescale 1ns/1ps

module conv_feeder (
	input logic clk,
	input logic rst,
	input logic i_start,
	input window_pkg::dim_t i_cols,
	input window_pkg::dim_t i_rows,
	input window_pkg::stride_e i_stride,
	input logic i_valid,
	input buffer_pkg::word_t i_data,
	output logic o_full,
	output logic o_valid,
	output buffer_pkg::word_t o_lane_data,
	output logic o_done
);

	logic we;
	buffer_pkg::buf_addr_t waddr;
	buffer_pkg::word_t wdata;

	row_sync_if sync_if ();
	buf_rd_if rd_if ();

	pixel_writer u_writer (
		.clk     (clk),
		.rst     (rst),
		.i_start (i_start),
		.i_cols  (i_cols),
		.i_rows  (i_rows),
		.i_valid (i_valid),
		.i_data  (i_data),
		.o_full  (o_full),
		.o_we    (we),
		.o_waddr (waddr),
		.o_wdata (wdata),
		.sync    (sync_if.writer)
	);

	line_buffer_ram u_ram (
		.clk     (clk),
		.i_we    (we),
		.i_waddr (waddr),
		.i_wdata (wdata),
		.rd      (rd_if.ram)
	);

	window_addr_gen u_addr_gen (
		.clk      (clk),
		.rst      (rst),
		.i_cols   (i_cols), // latched on frame_start
		.i_rows   (i_rows),
		.i_stride (i_stride),
		.sync     (sync_if.reader),
		.rd       (rd_if.gen)
	);

	lane_skew u_skew (
		.clk         (clk),
		.rst         (rst),
		.rd          (rd_if.sink),
		.o_valid     (o_valid),
		.o_lane_data (o_lane_data),
		.o_done      (o_done)
	);

endmodule

/* design/feeder_ifs.sv */
`timescale 1ns/1ps

// row bookkeeping between the writer and the window walk
interface row_sync_if;
	logic frame_start;
	window_pkg::dim_t rows_done; // complete rows written
	window_pkg::dim_t rows_freed; // rows the reader has let go
	logic frame_done;

	modport writer (
		output frame_start, rows_done,
		input rows_freed, frame_done
	);

	modport reader (
		input frame_start, rows_done,
		output rows_freed, frame_done
	);
endinterface

// read side of the line buffer
interface buf_rd_if;
	logic rd_en;
	buffer_pkg::buf_addr_t rd_addr;
	logic rd_last;
	buffer_pkg::word_t rd_data; // one cycle after rd_en

	modport gen (output rd_en, rd_addr, rd_last);
	modport ram (input rd_en, rd_addr, output rd_data);
	modport sink (input rd_en, rd_last, rd_data);
endinterface

/* design/feeder_macros.svh */
`ifndef FEEDER_MACROS_SVH
`define FEEDER_MACROS_SVH

// array side
`define FEEDER_LANES 4
`define FEEDER_LANE_WIDTH 8

// window side is a fixed 3x3
`define FEEDER_KERNEL 3

// ring of image rows held in the line buffer
`define FEEDER_RING_ROWS 4

// image limits
`define FEEDER_MAX_COLS 32
`define FEEDER_MAX_ROWS 32

`endif

/* design/lane_skew.sv */
`timescale 1ns/1ps
`include "feeder_macros.svh"

module lane_skew (
	input logic clk,
	input logic rst,
	buf_rd_if.sink rd,
	output logic o_valid,
	output buffer_pkg::word_t o_lane_data,
	output logic o_done
);

	logic en_q;
	logic last_q;

	// line up with the registered RAM output
	always_ff @(posedge clk) begin
		if (rst) begin
			en_q <= 1'b0;
			last_q <= 1'b0;
		end else begin
			en_q <= rd.rd_en;
			last_q <= rd.rd_last;
		end
	end

	assign o_valid = en_q; // follows lane 0
	assign o_done = last_q;

	// wavefront with lane i held back i cycles
	for (genvar i = 0; i < `FEEDER_LANES; i++) begin : g_lane
		buffer_pkg::lane_t lane_in;

		assign lane_in = rd.rd_data[i*`FEEDER_LANE_WIDTH +: `FEEDER_LANE_WIDTH];

		if (i == 0) begin : g_direct
			assign o_lane_data[i*`FEEDER_LANE_WIDTH +: `FEEDER_LANE_WIDTH] = lane_in;
		end else begin : g_delay
			buffer_pkg::lane_t dly [i];

			always_ff @(posedge clk) begin
				dly[0] <= lane_in;
				for (int k = 1; k < i; k++)
					dly[k] <= dly[k-1];
			end

			assign o_lane_data[i*`FEEDER_LANE_WIDTH +: `FEEDER_LANE_WIDTH] = dly[i-1];
		end
	end

endmodule

/* design/line_buffer_ram.sv */
`timescale 1ns/1ps
`include "feeder_macros.svh"

module line_buffer_ram (
	input logic clk,
	input logic i_we,
	input buffer_pkg::buf_addr_t i_waddr,
	input buffer_pkg::word_t i_wdata,
	buf_rd_if.ram rd
);

	// ring rows laid out back to back at max width each
	buffer_pkg::word_t mem [`FEEDER_RING_ROWS*`FEEDER_MAX_COLS];

	always_ff @(posedge clk) begin
		if (i_we)
			mem[i_waddr] <= i_wdata;
	end

	// registered read port
	always_ff @(posedge clk) begin
		if (rd.rd_en)
			rd.rd_data <= mem[rd.rd_addr];
	end

endmodule

/* design/pixel_writer.sv */
`timescale 1ns/1ps
`include "feeder_macros.svh"

module pixel_writer (
	input logic clk,
	input logic rst,
	input logic i_start,
	input window_pkg::dim_t i_cols,
	input window_pkg::dim_t i_rows,
	input logic i_valid,
	input buffer_pkg::word_t i_data,
	output logic o_full,
	output logic o_we,
	output buffer_pkg::buf_addr_t o_waddr,
	output buffer_pkg::word_t o_wdata,
	row_sync_if.writer sync
);

	window_pkg::wr_state_e state;
	window_pkg::dim_t cols_q;
	window_pkg::dim_t rows_q;
	window_pkg::dim_t col;
	window_pkg::dim_t row; // row being written and count of complete rows
	window_pkg::dim_t ahead;
	logic done_seen; // reader may finish before the unused bottom rows arrive

	assign sync.frame_start = (state == window_pkg::WR_IDLE) && i_start;
	assign sync.rows_done = row;

	// unread rows in the ring
	assign ahead = row - sync.rows_freed;
	assign o_full = (state == window_pkg::WR_FILL) &&
		(ahead == window_pkg::dim_t'(`FEEDER_RING_ROWS));

	assign o_we = (state == window_pkg::WR_FILL) && i_valid && !o_full;
	assign o_waddr = buffer_pkg::buf_addr_t'((row % `FEEDER_RING_ROWS) * `FEEDER_MAX_COLS + col);
	assign o_wdata = i_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= window_pkg::WR_IDLE;
			col <= '0;
			row <= '0;
			done_seen <= 1'b0;
		end else begin
			case (state)
				window_pkg::WR_IDLE: if (sync.frame_start) begin
					cols_q <= i_cols; // geometry held for the whole frame
					rows_q <= i_rows;
					col <= '0;
					row <= '0;
					done_seen <= 1'b0;
					state <= window_pkg::WR_FILL;
				end
				window_pkg::WR_FILL: begin
					if (sync.frame_done)
						done_seen <= 1'b1;
					if (o_we) begin
						if (col == window_pkg::dim_t'(cols_q - 1'b1)) begin
							col <= '0;
							row <= row + 1'b1; // row complete
							if (row == window_pkg::dim_t'(rows_q - 1'b1))
								state <= window_pkg::WR_DRAIN;
						end else begin
							col <= col + 1'b1;
						end
					end
				end
				window_pkg::WR_DRAIN: if (sync.frame_done || done_seen)
					state <= window_pkg::WR_IDLE;
				default: state <= window_pkg::WR_IDLE;
			endcase
		end
	end

endmodule

/* design/window_addr_gen.sv */
`timescale 1ns/1ps
`include "feeder_macros.svh"

module window_addr_gen (
	input logic clk,
	input logic rst,
	input window_pkg::dim_t i_cols,
	input window_pkg::dim_t i_rows,
	input window_pkg::stride_e i_stride,
	row_sync_if.reader sync,
	buf_rd_if.gen rd
);

	localparam int KW = $clog2(`FEEDER_KERNEL);

	window_pkg::rd_state_e state;
	window_pkg::dim_t cols_q;
	window_pkg::dim_t rows_q;
	window_pkg::stride_e stride_q;
	window_pkg::dim_t out_cols;
	window_pkg::dim_t out_rows;
	window_pkg::dim_t oy;
	window_pkg::dim_t ox;
	logic [KW-1:0] ky;
	logic [KW-1:0] kx;
	window_pkg::dim_t iy;
	window_pkg::dim_t ix;
	window_pkg::dim_t row_need;
	logic last_col;
	logic last_row;
	buffer_pkg::buf_addr_t tap_addr;

	// output index to image index
	function automatic window_pkg::dim_t scale(window_pkg::dim_t v, window_pkg::stride_e s);
		return (s == window_pkg::STRIDE_2) ? window_pkg::dim_t'(v << 1) : v;
	endfunction

	// windows along one side are (n - 3) / s + 1
	function automatic window_pkg::dim_t out_len(window_pkg::dim_t n, window_pkg::stride_e s);
		if (s == window_pkg::STRIDE_2)
			return window_pkg::dim_t'(((n - `FEEDER_KERNEL) >> 1) + 1);
		return window_pkg::dim_t'(n - `FEEDER_KERNEL + 1);
	endfunction

	assign out_cols = out_len(cols_q, stride_q);
	assign out_rows = out_len(rows_q, stride_q);

	assign iy = scale(oy, stride_q) + window_pkg::dim_t'(ky);
	assign ix = scale(ox, stride_q) + window_pkg::dim_t'(kx);
	assign row_need = scale(oy, stride_q) + window_pkg::dim_t'(`FEEDER_KERNEL); // bottom row of window + 1

	assign tap_addr = buffer_pkg::buf_addr_t'((iy % `FEEDER_RING_ROWS) * `FEEDER_MAX_COLS + ix);

	assign last_col = (ox == window_pkg::dim_t'(out_cols - 1'b1));
	assign last_row = (oy == window_pkg::dim_t'(out_rows - 1'b1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= window_pkg::RD_IDLE;
			rd.rd_en <= 1'b0;
			rd.rd_last <= 1'b0;
			sync.frame_done <= 1'b0;
			sync.rows_freed <= '0;
			oy <= '0;
			ox <= '0;
			ky <= '0;
			kx <= '0;
		end else begin
			rd.rd_en <= 1'b0;
			rd.rd_last <= 1'b0;
			sync.frame_done <= 1'b0;
			case (state)
				window_pkg::RD_IDLE: if (sync.frame_start) begin
					cols_q <= i_cols;
					rows_q <= i_rows;
					stride_q <= i_stride;
					oy <= '0;
					ox <= '0;
					ky <= '0;
					kx <= '0;
					sync.rows_freed <= '0;
					state <= window_pkg::RD_WAIT;
				end
				window_pkg::RD_WAIT: if (sync.rows_done >= row_need)
					state <= window_pkg::RD_SCAN;
				window_pkg::RD_SCAN: begin
					rd.rd_en <= 1'b1;
					rd.rd_addr <= tap_addr;
					// kx fastest, then ky, then output column
					if (kx != (`FEEDER_KERNEL - 1)) begin
						kx <= kx + 1'b1;
					end else begin
						kx <= '0;
						if (ky != (`FEEDER_KERNEL - 1)) begin
							ky <= ky + 1'b1;
						end else begin
							ky <= '0;
							if (!last_col) begin
								ox <= ox + 1'b1;
							end else begin
								// release top rows once the output row is finished
								ox <= '0;
								sync.rows_freed <= scale(oy + 1'b1, stride_q);
								if (last_row) begin
									rd.rd_last <= 1'b1;
									sync.frame_done <= 1'b1;
									state <= window_pkg::RD_IDLE;
								end else begin
									oy <= oy + 1'b1;
									state <= window_pkg::RD_WAIT;
								end
							end
						end
					end
				end
				default: state <= window_pkg::RD_IDLE;
			endcase
		end
	end

endmodule

/* design/window_pkg.sv */
`include "feeder_macros.svh"

package window_pkg;

	// row or column count wide enough to hold the max itself
	typedef logic [$clog2(`FEEDER_MAX_ROWS+1)-1:0] dim_t;

	typedef enum logic {
		STRIDE_1 = 1'b0,
		STRIDE_2 = 1'b1
	} stride_e;

	// input side
	typedef enum logic [1:0] {
		WR_IDLE  = 2'd0,
		WR_FILL  = 2'd1,
		WR_DRAIN = 2'd2 // last pixel in and waiting for the reader
	} wr_state_e;

	// window walk
	typedef enum logic [1:0] {
		RD_IDLE = 2'd0,
		RD_WAIT = 2'd1, // rows for the next output row not there yet
		RD_SCAN = 2'd2
	} rd_state_e;

endpackage

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_conv_feeder \
	-f conv_feeder.f -o tb_conv_feeder
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/tb_conv_feeder > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_PERIOD = 4 // 8 ns clock
) (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
		forever #(HALF_PERIOD) o_clk = ~o_clk;
	end

endmodule

/* tb/tb_conv_feeder.sv */
`timescale 1ns/1ps
`include "feeder_macros.svh"

module tb_conv_feeder;

	localparam int LW = `FEEDER_LANE_WIDTH;
	localparam int MAX_PIX = `FEEDER_MAX_COLS * `FEEDER_MAX_ROWS;

	// pixels plus nine reads per window summed over every frame
	localparam int WORK = (48 + 9 * 24)   // 8x6 stride 1
		+ (81 + 9 * 16)                  // 9x9 stride 2
		+ (240 + 9 * 180)                // 20x12 with stalls
		+ (9 + 9 * 1)                    // 3x3
		+ (70 + 9 * 40)                  // 10x7 with second start
		+ (96 + 9 * 60) + (48 + 9 * 24); // aborted 12x8, then 8x6
	localparam int CYCLE_LIMIT = WORK * 4 + 1000;

	logic clk;
	logic rst;
	logic i_start;
	window_pkg::dim_t i_cols;
	window_pkg::dim_t i_rows;
	window_pkg::stride_e i_stride;
	logic i_valid;
	buffer_pkg::word_t i_data;
	logic o_full;
	logic o_valid;
	buffer_pkg::word_t o_lane_data;
	logic o_done;

	logic [31:0] lfsr;
	buffer_pkg::word_t img [MAX_PIX]; // raster order as y * cols + x
	buffer_pkg::word_t exp_words [$];
	buffer_pkg::word_t hist_word [`FEEDER_LANES]; // word that left lane 0 i cycles ago
	logic hist_vld [`FEEDER_LANES];
	int exp_total;
	int words_seen;
	int done_count;
	int full_seen;
	int cycles = 0;

	tb_clock u_clk (.o_clk(clk));

	conv_feeder dut (
		.clk         (clk),
		.rst         (rst),
		.i_start     (i_start),
		.i_cols      (i_cols),
		.i_rows      (i_rows),
		.i_stride    (i_stride),
		.i_valid     (i_valid),
		.i_data      (i_data),
		.o_full      (o_full),
		.o_valid     (o_valid),
		.o_lane_data (o_lane_data),
		.o_done      (o_done)
	);

	task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			$display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic random_word(output buffer_pkg::word_t w);
		for (int b = 0; b < $bits(w); b++) begin
			w[b] = lfsr[0]; // one step per bit
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic fill_image(input int cols, input int rows);
		buffer_pkg::word_t w;
		for (int p = 0; p < cols * rows; p++) begin
			random_word(w);
			img[p] = w;
		end
	endtask

	// windows in column then row order with taps ky then kx inside
	task automatic build_expected(input int cols, input int rows, input int s);
		int out_c;
		int out_r;
		out_c = (cols - `FEEDER_KERNEL) / s + 1;
		out_r = (rows - `FEEDER_KERNEL) / s + 1;
		exp_total = 0;
		for (int oy = 0; oy < out_r; oy++)
			for (int ox = 0; ox < out_c; ox++)
				for (int ky = 0; ky < `FEEDER_KERNEL; ky++)
					for (int kx = 0; kx < `FEEDER_KERNEL; kx++) begin
						exp_words.push_back(img[(oy * s + ky) * cols + ox * s + kx]);
						exp_total++;
					end
	endtask

	task automatic reset_counters();
		words_seen = 0;
		done_count = 0;
		full_seen = 0;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b1;
		i_start = 1'b0;
		i_valid = 1'b0;
		repeat (9) @(negedge clk);
		exp_words.delete(); // monitor idle while rst is high
		reset_counters();
		@(negedge clk);
		rst = 1'b0;
	endtask

	task automatic start_frame(input int cols, input int rows, input window_pkg::stride_e s);
		@(negedge clk);
		i_cols = window_pkg::dim_t'(cols);
		i_rows = window_pkg::dim_t'(rows);
		i_stride = s;
		i_start = 1'b1;
		@(negedge clk);
		i_start = 1'b0;
	endtask

	// source holds each pixel while o_full is high
	task automatic stream_pixels(input int cols, input int rows, input int count,
			input int restart_at);
		for (int p = 0; p < count; p++) begin
			@(negedge clk);
			i_valid = 1'b1;
			i_data = img[p];
			i_start = (p == restart_at); // mid frame start with other geometry
			i_cols = window_pkg::dim_t'((p == restart_at) ? 5 : cols);
			i_rows = window_pkg::dim_t'((p == restart_at) ? 5 : rows);
			while (o_full) begin
				full_seen++;
				@(negedge clk);
			end
		end
		@(negedge clk);
		i_valid = 1'b0;
		i_start = 1'b0;
	endtask

	task automatic wait_frame_end();
		while (done_count == 0)
			@(negedge clk);
		repeat (`FEEDER_LANES) @(negedge clk); // let the wavefront drain
		check_equal(32'(exp_words.size()), 32'd0, "words never emitted");
		check_equal(words_seen, exp_total, "word count");
		check_equal(done_count, 32'd1, "o_done pulses");
	endtask

	task automatic run_frame(input int cols, input int rows, input window_pkg::stride_e s,
			input int restart_at);
		reset_counters();
		fill_image(cols, rows);
		build_expected(cols, rows, (s == window_pkg::STRIDE_2) ? 2 : 1);
		start_frame(cols, rows, s);
		stream_pixels(cols, rows, cols * rows, restart_at);
		wait_frame_end();
	endtask

	task automatic test_stride1();
		run_frame(8, 6, window_pkg::STRIDE_1, -1);
		check_equal(words_seen, 6 * 4 * 9, "stride 1 words");
	endtask

	task automatic test_stride2();
		run_frame(9, 9, window_pkg::STRIDE_2, -1);
		check_equal(words_seen, 4 * 4 * 9, "stride 2 words");
	endtask

	task automatic test_full_stall();
		run_frame(20, 12, window_pkg::STRIDE_1, -1);
		check_equal(32'(full_seen > 0), 32'd1, "o_full seen while streaming");
	endtask

	task automatic test_lane_skew();
		run_frame(3, 3, window_pkg::STRIDE_1, -1);
		check_equal(words_seen, 9, "single window words");
	endtask

	task automatic test_start_ignored();
		run_frame(10, 7, window_pkg::STRIDE_1, 30);
		check_equal(words_seen, 8 * 5 * 9, "words with second start");
	endtask

	task automatic test_reset_idle();
		reset_counters();
		fill_image(12, 8);
		build_expected(12, 8, 1);
		start_frame(12, 8, window_pkg::STRIDE_1);
		stream_pixels(12, 8, 60, -1); // stops partway with output already running
		apply_reset();
		repeat (3) begin
			@(negedge clk);
			check_equal(o_full, 1'b0, "o_full after reset");
			check_equal(o_valid, 1'b0, "o_valid after reset");
			check_equal(o_done, 1'b0, "o_done after reset");
		end
		run_frame(8, 6, window_pkg::STRIDE_1, -1);
	endtask

	// lane i checked i cycles after its word showed on lane 0
	always @(negedge clk) begin
		if (rst) begin
			for (int i = 0; i < `FEEDER_LANES; i++)
				hist_vld[i] = 1'b0;
		end else begin
			for (int i = `FEEDER_LANES - 1; i > 0; i--) begin
				hist_word[i] = hist_word[i-1];
				hist_vld[i] = hist_vld[i-1];
			end
			hist_vld[0] = o_valid;
			if (o_valid) begin
				check_equal(32'(exp_words.size() != 0), 32'd1, "word expected on o_valid");
				hist_word[0] = exp_words.pop_front();
				words_seen++;
			end
			if (o_done) begin
				done_count++;
				check_equal(o_valid, 1'b1, "o_valid with o_done");
				check_equal(32'(exp_words.size()), 32'd0, "o_done on final word");
			end
			for (int i = 0; i < `FEEDER_LANES; i++)
				if (hist_vld[i])
					check_equal(32'(o_lane_data[i*LW +: LW]), 32'(hist_word[i][i*LW +: LW]),
						$sformatf("lane %0d", i));
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$fatal(1, "cycle limit reached");
		end
	end

	initial begin
		rst = 1'b1;
		i_start = 1'b0;
		i_cols = '0;
		i_rows = '0;
		i_stride = window_pkg::STRIDE_1;
		i_valid = 1'b0;
		i_data = '0;
		lfsr = 32'ha08e_d934;
		exp_total = 0;
		reset_counters();
		apply_reset();
		test_stride1();
		test_stride2();
		test_full_stall();
		test_lane_skew();
		test_start_ignored();
		test_reset_idle();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
